//--- axis_generator_vectors.txt
# id width height pattern ready(0 always,1 random,2 burst) frames pause_at new_width new_height
# then left top width height for each of the eight windows
1 16 8 0 0 2 0 16 8   0 0 4 4  2 2 4 4  12 4 4 4  0 0 16 8  5 5 0 3  3 6 2 0  15 7 1 1  10 0 50 50
2 1 5 1 0 3 0 1 5   0 0 1 1  0 2 1 2  0 4 1 1  0 0 1 5  0 0 0 0  1 0 1 1  0 1 3 3  0 3 2 9
3 20 12 2 1 2 0 20 12   0 0 8 8  4 4 8 8  16 0 4 12  0 0 20 12  7 7 0 0  19 11 1 1  0 11 20 1  9 2 3 5
4 9 3 3 2 3 0 9 3   0 0 3 3  2 0 3 3  8 2 1 1  0 0 9 3  4 1 0 1  0 0 9 1  6 0 3 9  1 1 1 1
5 12 6 2 1 2 30 7 4   0 0 4 4  2 2 4 4  6 0 6 6  0 0 12 6  1 1 0 5  11 5 1 1  0 5 12 1  3 3 9 9
6 5 1 0 2 4 3 5 1   0 0 1 1  1 0 2 1  4 0 1 1  0 0 5 1  2 0 0 1  0 0 5 0  3 0 9 9  2 0 1 1
7 17 17 2 0 1 0 17 17   0 0 9 9  8 8 9 9  16 16 1 1  0 0 17 17  3 3 0 0  0 8 17 1  8 0 1 17  5 5 5 5
8 3 2 1 1 3 4 4 3   0 0 1 1  1 0 2 2  2 1 1 1  0 0 3 2  0 0 0 2  0 1 4 1  3 0 1 3  1 1 9 9

//--- axis_generator.f
axis_gen_pkg.sv
frame_scanner.sv
window_hit.sv
pixel_pattern.sv
axis_generator.sv
axis_generator_assertions.sv
axis_checker.sv
tb_axis_generator.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it, and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f axis_generator.f \
	--top-module tb_axis_generator -Mdir obj_dir -o sim_axis_generator \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_axis_generator > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation did not finish"; exit 1; }

//--- tb_axis_generator.sv
`timescale 1ns/1ps

module tb_axis_generator;
	import axis_gen_pkg::*;

	localparam int max_tests = 16;
	localparam int pause_cycles = 10;
	localparam int n_fields = 9 + 4*win_num;

	logic                   clk;
	logic                   resetn;
	logic                   enable;
	logic [img_wbits-1:0]   frame_width;
	logic [img_hbits-1:0]   frame_height;
	logic [pat_bits-1:0]    pattern;
	logic [img_wbits-1:0]   win_left   [win_num];
	logic [img_hbits-1:0]   win_top    [win_num];
	logic [img_wbits-1:0]   win_width  [win_num];
	logic [img_hbits-1:0]   win_height [win_num];
	logic                   m_axis_tvalid;
	logic [pixel_width-1:0] m_axis_tdata;
	logic                   m_axis_tuser;
	logic                   m_axis_tlast;
	logic                   m_axis_tready;
	logic [win_num-1:0]     win_pixel_need;

	logic start;
	logic done;
	int   cur_test;
	int   cur_frames;
	int   ready_mode;
	int   burst_count;
	int   seed;
	int   limit_cycles;
	int   error_count;
	int   check_count;
	int   test_count;
	int   failed_tests;
	int   bad_lines;

	// Test table, one entry per vector line.
	int n_tests;
	int t_id     [max_tests];
	int t_w      [max_tests];
	int t_h      [max_tests];
	int t_pat    [max_tests];
	int t_ready  [max_tests];
	int t_frames [max_tests];
	int t_pause  [max_tests];
	int t_nw     [max_tests];
	int t_nh     [max_tests];
	int t_win    [max_tests][4*win_num];

	axis_generator u_axis_generator (
		.clk            (clk),
		.resetn         (resetn),
		.enable         (enable),
		.frame_width    (frame_width),
		.frame_height   (frame_height),
		.pattern        (pattern),
		.win_left       (win_left),
		.win_top        (win_top),
		.win_width      (win_width),
		.win_height     (win_height),
		.m_axis_tvalid  (m_axis_tvalid),
		.m_axis_tdata   (m_axis_tdata),
		.m_axis_tuser   (m_axis_tuser),
		.m_axis_tlast   (m_axis_tlast),
		.m_axis_tready  (m_axis_tready),
		.win_pixel_need (win_pixel_need)
	);

	axis_checker u_axis_checker (
		.clk            (clk),
		.resetn         (resetn),
		.start          (start),
		.test_id        (cur_test),
		.frames         (cur_frames),
		.frame_width    (frame_width),
		.frame_height   (frame_height),
		.pattern        (pattern),
		.win_left       (win_left),
		.win_top        (win_top),
		.win_width      (win_width),
		.win_height     (win_height),
		.tvalid         (m_axis_tvalid),
		.tready         (m_axis_tready),
		.tdata          (m_axis_tdata),
		.tuser          (m_axis_tuser),
		.tlast          (m_axis_tlast),
		.mask           (win_pixel_need),
		.done           (done),
		.error_count    (error_count),
		.check_count    (check_count),
		.test_count     (test_count),
		.failed_tests   (failed_tests)
	);

	bind axis_generator axis_generator_assertions u_assertions (
		.clk     (clk),
		.resetn  (resetn),
		.tvalid  (m_axis_tvalid),
		.tready  (m_axis_tready),
		.tuser   (m_axis_tuser),
		.tlast   (m_axis_tlast),
		.tdata   (m_axis_tdata),
		.mask    (win_pixel_need),
		.pix_col (pix_col)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////
	// Ready patterns
	////////////////////////////////////////

	// Mode 0 is always ready, mode 1 random, mode 2 a stall of three in eight.
	always @(posedge clk) begin
		burst_count <= burst_count + 1;
		case (ready_mode)
			1: m_axis_tready <= (($random(seed) & 3) != 0);
			2: m_axis_tready <= ((burst_count % 8) < 5);
			default: m_axis_tready <= 1'b1;
		endcase
	end

	task automatic load_vectors(input int fd);
		string line;
		int    code;
		int    v [n_fields];
		int    count;
		int    acc;
		bit    in_num;
		int    c;
		int    i;
		n_tests = 0;
		while (!$feof(fd) && n_tests < max_tests) begin
			code = $fgets(line, fd);
			if (code > 1 && line[0] != "#") begin
				// Split the line into its decimal fields.
				count  = 0;
				acc    = 0;
				in_num = 1'b0;
				for (c = 0; c <= line.len(); c++) begin
					if (c < line.len() && line[c] >= "0" && line[c] <= "9") begin
						acc    = acc * 10 + int'(line[c] - "0");
						in_num = 1'b1;
					end else if (in_num) begin
						if (count < n_fields) begin
							v[count] = acc;
						end
						count++;
						acc    = 0;
						in_num = 1'b0;
					end
				end
				if (count == n_fields) begin
					t_id[n_tests]     = v[0];
					t_w[n_tests]      = v[1];
					t_h[n_tests]      = v[2];
					t_pat[n_tests]    = v[3];
					t_ready[n_tests]  = v[4];
					t_frames[n_tests] = v[5];
					t_pause[n_tests]  = v[6];
					t_nw[n_tests]     = v[7];
					t_nh[n_tests]     = v[8];
					for (i = 0; i < 4*win_num; i++) begin
						t_win[n_tests][i] = v[9 + i];
					end
					n_tests++;
				end else begin
					bad_lines++;
					$display("malformed vector line: %s", line);
				end
			end
		end
	endtask

	task automatic run_test(input int i);
		int total;
		int loads;
		int k;
		bit paused;
		@(posedge clk);
		frame_width  <= img_wbits'(t_w[i]);
		frame_height <= img_hbits'(t_h[i]);
		pattern      <= pat_bits'(t_pat[i]);
		for (k = 0; k < win_num; k++) begin
			win_left[k]   <= img_wbits'(t_win[i][4*k]);
			win_top[k]    <= img_hbits'(t_win[i][4*k+1]);
			win_width[k]  <= img_wbits'(t_win[i][4*k+2]);
			win_height[k] <= img_hbits'(t_win[i][4*k+3]);
		end
		ready_mode <= t_ready[i];
		@(posedge clk);
		start      <= 1'b1;
		cur_test   <= t_id[i];
		cur_frames <= t_frames[i];
		@(posedge clk);
		start  <= 1'b0;
		enable <= 1'b1;
		total  = t_w[i] * t_h[i] + (t_frames[i] - 1) * t_nw[i] * t_nh[i];
		loads  = 0;
		paused = 1'b0;
		// Enable must be low on the edge after the final pixel is loaded.
		while (loads < total) begin
			@(posedge clk);
			if (enable && (!m_axis_tvalid || m_axis_tready)) begin
				loads++;
			end
			if (loads == total) begin
				enable <= 1'b0;
			end else if (!paused && t_pause[i] != 0 && loads == t_pause[i]) begin
				enable <= 1'b0;
				paused = 1'b1;
				repeat (pause_cycles) @(posedge clk);
				frame_width  <= img_wbits'(t_nw[i]);
				frame_height <= img_hbits'(t_nh[i]);
				enable       <= 1'b1;
			end
		end
		while (!done) @(posedge clk);
		while (m_axis_tvalid) @(posedge clk);
	endtask

	initial begin
		int fd;
		int i;
		resetn       = 1'b0;
		enable       = 1'b0;
		frame_width  = '0;
		frame_height = '0;
		pattern      = '0;
		for (i = 0; i < win_num; i++) begin
			win_left[i]   = '0;
			win_top[i]    = '0;
			win_width[i]  = '0;
			win_height[i] = '0;
		end
		m_axis_tready = 1'b0;
		start         = 1'b0;
		cur_test      = 0;
		cur_frames    = 0;
		ready_mode    = 0;
		burst_count   = 0;
		seed          = 32'h5c94_dd00;
		limit_cycles  = 0;
		bad_lines     = 0;

		fd = $fopen("axis_generator_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open axis_generator_vectors.txt");
			$display("TEST RESULT: FAIL");
			$finish;
		end else begin
			load_vectors(fd);
			$fclose(fd);
			limit_cycles = 2000 + 16;
			for (i = 0; i < n_tests; i++) begin
				limit_cycles += 8 * t_frames[i] *
					((t_w[i] * t_h[i] > t_nw[i] * t_nh[i]) ?
					t_w[i] * t_h[i] : t_nw[i] * t_nh[i]);
			end
			repeat (16) @(posedge clk);
			resetn <= 1'b1;
			for (i = 0; i < n_tests; i++) begin
				run_test(i);
			end
			repeat (4) @(posedge clk);
			$display("tests %0d, failed %0d, checks %0d, errors %0d",
				test_count, failed_tests, check_count, error_count);
			if (n_tests > 0 && test_count == n_tests && error_count == 0 &&
				bad_lines == 0) begin
				$display("TEST RESULT: PASS");
			end else begin
				$display("TEST RESULT: FAIL");
			end
			$finish;
		end
	end

	// Watchdog sized from the frames in the vector file.
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the stream stopped early",
			limit_cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- axis_checker.sv
`timescale 1ns/1ps

module axis_checker (
	input  logic                                 clk,
	input  logic                                 resetn,
	input  logic                                 start,
	input  int                                   test_id,
	input  int                                   frames,
	input  logic [axis_gen_pkg::img_wbits-1:0]   frame_width,
	input  logic [axis_gen_pkg::img_hbits-1:0]   frame_height,
	input  logic [axis_gen_pkg::pat_bits-1:0]    pattern,
	input  logic [axis_gen_pkg::img_wbits-1:0]   win_left   [axis_gen_pkg::win_num],
	input  logic [axis_gen_pkg::img_hbits-1:0]   win_top    [axis_gen_pkg::win_num],
	input  logic [axis_gen_pkg::img_wbits-1:0]   win_width  [axis_gen_pkg::win_num],
	input  logic [axis_gen_pkg::img_hbits-1:0]   win_height [axis_gen_pkg::win_num],
	input  logic                                 tvalid,
	input  logic                                 tready,
	input  logic [axis_gen_pkg::pixel_width-1:0] tdata,
	input  logic                                 tuser,
	input  logic                                 tlast,
	input  logic [axis_gen_pkg::win_num-1:0]     mask,
	output logic                                 done,
	output int                                   error_count,
	output int                                   check_count,
	output int                                   test_count,
	output int                                   failed_tests
);
	import axis_gen_pkg::*;

	int   exp_col;
	int   exp_row;
	int   cur_w;
	int   cur_h;
	int   cur_pat;
	int   frame_idx;
	int   beat_idx;
	int   test_errors;
	bit   active;
	bit   stalled;
	logic [pixel_width-1:0] held_data;
	logic                   held_user;
	logic                   held_last;
	logic [win_num-1:0]     held_mask;

	function automatic int expected_data(input int col, input int row, input int pat);
		int bit_pos;
		int full;
		bit_pos = 1 << checker_shift;
		full    = (1 << pixel_width) - 1;
		if (pat == int'(pat_col_ramp)) return col % (full + 1);
		if (pat == int'(pat_row_ramp)) return row % (full + 1);
		if (pat == int'(pat_checker)) begin
			return (((col / bit_pos) + (row / bit_pos)) % 2 == 1) ? full : 0;
		end
		return 0;
	endfunction

	function automatic bit inside_window(input int col, input int row, input int l,
		input int t, input int w, input int h);
		return (w > 0) && (h > 0) && (col >= l) && (col < l + w) &&
			(row >= t) && (row < t + h);
	endfunction

	task automatic compare_field(input string name, input int exp, input int got);
		check_count++;
		if (exp != got) begin
			error_count++;
			test_errors++;
			$display("error %0t: test %0d beat %0d %s expected %0h got %0h",
				$time, test_id, beat_idx, name, exp, got);
		end
	endtask

	initial begin
		error_count  = 0;
		check_count  = 0;
		test_count   = 0;
		failed_tests = 0;
		active       = 0;
		stalled      = 0;
		done         = 1'b0;
	end

	always @(posedge clk) begin
		int k;
		int exp_mask;
		if (resetn) begin
			// A stalled beat must still be there, unchanged, one edge later.
			if (stalled) begin
				compare_field("tvalid held", 1, int'(tvalid));
				compare_field("tdata held", int'(held_data), int'(tdata));
				compare_field("tuser held", int'(held_user), int'(tuser));
				compare_field("tlast held", int'(held_last), int'(tlast));
				compare_field("mask held", int'(held_mask), int'(mask));
			end
			stalled   = tvalid && !tready;
			held_data = tdata;
			held_user = tuser;
			held_last = tlast;
			held_mask = mask;

			if (start) begin
				active      = 1;
				done       <= 1'b0;
				exp_col     = 0;
				exp_row     = 0;
				frame_idx   = 0;
				beat_idx    = 0;
				test_errors = 0;
				cur_w       = int'(frame_width);
				cur_h       = int'(frame_height);
				cur_pat     = int'(pattern);
			end else if (tvalid && tready && !active) begin
				error_count++;
				$display("a beat was transferred at %0t while no test was running", $time);
			end else if (tvalid && tready) begin
				exp_mask = 0;
				for (k = 0; k < win_num; k++) begin
					if (inside_window(exp_col, exp_row, int'(win_left[k]), int'(win_top[k]),
						int'(win_width[k]), int'(win_height[k]))) begin
						exp_mask = exp_mask | (1 << k);
					end
				end
				compare_field("tdata", expected_data(exp_col, exp_row, cur_pat), int'(tdata));
				compare_field("tuser", int'(exp_col == 0 && exp_row == 0), int'(tuser));
				compare_field("tlast", int'(exp_col == cur_w - 1), int'(tlast));
				compare_field("win_pixel_need", exp_mask, int'(mask));
				beat_idx++;
				if (exp_col == cur_w - 1) begin
					exp_col = 0;
					if (exp_row == cur_h - 1) begin
						// The next frame takes whatever size is applied now.
						exp_row = 0;
						frame_idx++;
						cur_w   = int'(frame_width);
						cur_h   = int'(frame_height);
						cur_pat = int'(pattern);
					end else begin
						exp_row++;
					end
				end else begin
					exp_col++;
				end
				if (frame_idx == frames) begin
					active = 0;
					done  <= 1'b1;
					test_count++;
					if (test_errors != 0) failed_tests++;
					$display("test %0d: %0d frames, %0d beats, %0d errors",
						test_id, frames, beat_idx, test_errors);
				end
			end
		end
	end

endmodule

//--- axis_generator_assertions.sv
`timescale 1ns/1ps

module axis_generator_assertions (
	input logic                                 clk,
	input logic                                 resetn,
	input logic                                 tvalid,
	input logic                                 tready,
	input logic                                 tuser,
	input logic                                 tlast,
	input logic [axis_gen_pkg::pixel_width-1:0] tdata,
	input logic [axis_gen_pkg::win_num-1:0]     mask,
	input logic [axis_gen_pkg::img_wbits-1:0]   pix_col
);
	import axis_gen_pkg::*;

	// Reset is synchronous, so tvalid is low from the edge after it is seen.
	a_reset_idle: assert property (@(posedge clk) !resetn |=> !tvalid)
		else $error("tvalid high during reset");

	a_stall_hold: assert property (@(posedge clk) disable iff (!resetn)
		tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tuser) &&
		$stable(tlast) && $stable(mask))
		else $error("beat changed while stalled");

	a_user_col0: assert property (@(posedge clk) disable iff (!resetn)
		tvalid && tuser |-> pix_col == '0)
		else $error("tuser high away from column 0");

endmodule

//--- axis_generator.sv
`timescale 1ns/1ps

module axis_generator (
	input  logic                                 clk,
	input  logic                                 resetn,
	input  logic                                 enable,
	input  logic [axis_gen_pkg::img_wbits-1:0]   frame_width,
	input  logic [axis_gen_pkg::img_hbits-1:0]   frame_height,
	input  logic [axis_gen_pkg::pat_bits-1:0]    pattern,
	input  logic [axis_gen_pkg::img_wbits-1:0]   win_left   [axis_gen_pkg::win_num],
	input  logic [axis_gen_pkg::img_hbits-1:0]   win_top    [axis_gen_pkg::win_num],
	input  logic [axis_gen_pkg::img_wbits-1:0]   win_width  [axis_gen_pkg::win_num],
	input  logic [axis_gen_pkg::img_hbits-1:0]   win_height [axis_gen_pkg::win_num],
	output logic                                 m_axis_tvalid,
	output logic [axis_gen_pkg::pixel_width-1:0] m_axis_tdata,
	output logic                                 m_axis_tuser,
	output logic                                 m_axis_tlast,
	input  logic                                 m_axis_tready,
	output logic [axis_gen_pkg::win_num-1:0]     win_pixel_need
);
	import axis_gen_pkg::*;

	logic [img_wbits-1:0] pix_col;
	logic [img_hbits-1:0] pix_row;
	logic [pat_bits-1:0]  pat_latched;

	////////////////////////////////////////
	// Raster scan
	////////////////////////////////////////

	frame_scanner u_frame_scanner (
		.clk          (clk),
		.resetn       (resetn),
		.enable       (enable),
		.frame_width  (frame_width),
		.frame_height (frame_height),
		.pattern      (pattern),
		.tready       (m_axis_tready),
		.tvalid       (m_axis_tvalid),
		.tuser        (m_axis_tuser),
		.tlast        (m_axis_tlast),
		.pix_col      (pix_col),
		.pix_row      (pix_row),
		.pat_latched  (pat_latched)
	);

	////////////////////////////////////////
	// Beat payload
	////////////////////////////////////////

	// Data and mask are decoded from the registered coordinates, so they
	// stay aligned with tvalid, tuser and tlast.
	pixel_pattern u_pixel_pattern (
		.pix_col (pix_col),
		.pix_row (pix_row),
		.pattern (pat_latched),
		.data    (m_axis_tdata)
	);

	for (genvar i = 0; i < win_num; i++) begin : g_win
		window_hit u_window_hit (
			.pix_col    (pix_col),
			.pix_row    (pix_row),
			.win_left   (win_left[i]),
			.win_top    (win_top[i]),
			.win_width  (win_width[i]),
			.win_height (win_height[i]),
			.hit        (win_pixel_need[i])
		);
	end

endmodule

//--- pixel_pattern.sv
`timescale 1ns/1ps

module pixel_pattern (
	input  logic [axis_gen_pkg::img_wbits-1:0]   pix_col,
	input  logic [axis_gen_pkg::img_hbits-1:0]   pix_row,
	input  logic [axis_gen_pkg::pat_bits-1:0]    pattern,
	output logic [axis_gen_pkg::pixel_width-1:0] data
);
	import axis_gen_pkg::*;

	logic checker_on;

	// Squares alternate wherever exactly one of the two coordinates sits
	// in an odd-numbered square.
	assign checker_on = pix_col[checker_shift] ^ pix_row[checker_shift];

	always_comb begin
		case (pattern)
			pat_col_ramp: begin
				data = pix_col[pixel_width-1:0];
			end
			pat_row_ramp: begin
				data = pix_row[pixel_width-1:0];
			end
			pat_checker: begin
				data = {pixel_width{checker_on}};
			end
			default: begin
				// Code 3 is unused.
				data = '0;
			end
		endcase
	end

endmodule

//--- window_hit.sv
`timescale 1ns/1ps

module window_hit (
	input  logic [axis_gen_pkg::img_wbits-1:0] pix_col,
	input  logic [axis_gen_pkg::img_hbits-1:0] pix_row,
	input  logic [axis_gen_pkg::img_wbits-1:0] win_left,
	input  logic [axis_gen_pkg::img_hbits-1:0] win_top,
	input  logic [axis_gen_pkg::img_wbits-1:0] win_width,
	input  logic [axis_gen_pkg::img_hbits-1:0] win_height,
	output logic                               hit
);
	import axis_gen_pkg::*;

	// One extra bit keeps windows that run past the coordinate range from
	// wrapping back to the left or top.
	logic [img_wbits:0] win_right;
	logic [img_hbits:0] win_bottom;
	logic               win_empty;
	logic               in_cols;
	logic               in_rows;

	assign win_right  = {1'b0, win_left} + {1'b0, win_width} - (img_wbits + 1)'(1);
	assign win_bottom = {1'b0, win_top} + {1'b0, win_height} - (img_hbits + 1)'(1);

	// A zero-sized window would give an edge below its origin.
	assign win_empty = (win_width == '0) || (win_height == '0);

	assign in_cols = (pix_col >= win_left) && ({1'b0, pix_col} <= win_right);
	assign in_rows = (pix_row >= win_top) && ({1'b0, pix_row} <= win_bottom);

	assign hit = !win_empty && in_cols && in_rows;

endmodule

//--- frame_scanner.sv
`timescale 1ns/1ps

module frame_scanner (
	input  logic                               clk,
	input  logic                               resetn,
	input  logic                               enable,
	input  logic [axis_gen_pkg::img_wbits-1:0] frame_width,
	input  logic [axis_gen_pkg::img_hbits-1:0] frame_height,
	input  logic [axis_gen_pkg::pat_bits-1:0]  pattern,
	input  logic                               tready,
	output logic                               tvalid,
	output logic                               tuser,
	output logic                               tlast,
	output logic [axis_gen_pkg::img_wbits-1:0] pix_col,
	output logic [axis_gen_pkg::img_hbits-1:0] pix_row,
	output logic [axis_gen_pkg::pat_bits-1:0]  pat_latched
);
	import axis_gen_pkg::*;

	logic [img_wbits-1:0] lat_width;
	logic [img_hbits-1:0] lat_height;
	logic                 first_pending;
	logic                 slot_free;
	logic                 load;
	logic                 col_last;
	logic                 row_last;
	logic                 frame_done;
	logic [img_wbits-1:0] col_inc;

	////////////////////////////////////////
	// Load control
	////////////////////////////////////////

	// The output register can take a new pixel when it is empty or when
	// its current beat transfers on this edge.
	assign slot_free = !tvalid || tready;
	assign load      = enable && slot_free;

	// The coordinates always hold the last loaded pixel, so the next one
	// follows from them even after the stream has been paused.
	assign col_last   = (pix_col == lat_width - img_wbits'(1));
	assign row_last   = (pix_row == lat_height - img_hbits'(1));
	assign frame_done = first_pending || (col_last && row_last);
	assign col_inc    = pix_col + img_wbits'(1);

	////////////////////////////////////////
	// Raster counters and output beat
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			tvalid        <= 1'b0;
			tuser         <= 1'b0;
			tlast         <= 1'b0;
			first_pending <= 1'b1;
			pix_col       <= '0;
			pix_row       <= '0;
			lat_width     <= '0;
			lat_height    <= '0;
			pat_latched   <= '0;
		end else if (load) begin
			tvalid        <= 1'b1;
			first_pending <= 1'b0;
			if (frame_done) begin
				// A new frame picks up the size and pattern present right now.
				pix_col     <= '0;
				pix_row     <= '0;
				lat_width   <= frame_width;
				lat_height  <= frame_height;
				pat_latched <= pattern;
				tuser       <= 1'b1;
				tlast       <= (frame_width == img_wbits'(1));
			end else if (col_last) begin
				pix_col <= '0;
				pix_row <= pix_row + img_hbits'(1);
				tuser   <= 1'b0;
				tlast   <= (lat_width == img_wbits'(1));
			end else begin
				pix_col <= col_inc;
				tuser   <= 1'b0;
				tlast   <= (col_inc == lat_width - img_wbits'(1));
			end
		end else if (slot_free) begin
			// Enable is low: the stream goes idle but keeps its position.
			tvalid <= 1'b0;
			tuser  <= 1'b0;
			tlast  <= 1'b0;
		end
	end

endmodule

//--- axis_gen_pkg.sv
package axis_gen_pkg;

	////////////////////////////////////////
	// Stream and frame geometry
	////////////////////////////////////////

	// Bits of one pixel on tdata.
	localparam int pixel_width = 8;

	// Column and row coordinates share their width with the frame size fields.
	localparam int img_wbits = 12;
	localparam int img_hbits = 12;

	// Number of windows tested per pixel, one mask bit each.
	localparam int win_num = 8;

	////////////////////////////////////////
	// Test patterns
	////////////////////////////////////////

	localparam int pat_bits = 2;

	localparam logic [pat_bits-1:0] pat_col_ramp = 2'd0;
	localparam logic [pat_bits-1:0] pat_row_ramp = 2'd1;
	localparam logic [pat_bits-1:0] pat_checker  = 2'd2;

	// Checkerboard squares are 2**checker_shift pixels on a side.
	localparam int checker_shift = 3;

endpackage
